/* compile.f */
src/exe_pkg.sv
src/exe_alu.sv
src/dispatch_stage.sv
src/exe_stage.sv
src/wb_regfile.sv
src/exe_top.sv
verif/tb_clk_gen.sv
verif/exe_checker.sv
verif/exe_monitor.sv
verif/exe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exe_tb \
    -f compile.f -Mdir obj_dir -o exe_sim

./obj_dir/exe_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* src/dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage
    import exe_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  uop_t              uop_i,
    output logic [REG_W-1:0]  rf_rs1_idx_o,
    output logic [REG_W-1:0]  rf_rs2_idx_o,
    input  logic [XLEN-1:0]   rf_rs1_data_i,
    input  logic [XLEN-1:0]   rf_rs2_data_i,
    input  wb_port_t          fwd_exe_i,
    input  wb_port_t          fwd_wb_i,
    output exe_uop_t          exe_uop_o
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    exe_uop_t        op_d;
    exe_uop_t        op_q;     // payload, no reset
    logic            valid_q;

    // youngest producer wins: execute, then writeback, then the file
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_W-1:0] idx,
        input logic [XLEN-1:0]  rf_data,
        input wb_port_t         exe_fwd,
        input wb_port_t         wb_fwd
    );
        if (idx == '0)
            return '0;                                  // x0 hardwired
        if (exe_fwd.valid && (exe_fwd.rd_idx == idx))
            return exe_fwd.data;
        if (wb_fwd.valid && (wb_fwd.rd_idx == idx))
            return wb_fwd.data;
        return rf_data;
    endfunction

    assign rf_rs1_idx_o = uop_i.rs1_idx;
    assign rf_rs2_idx_o = uop_i.rs2_idx;

    assign rs1_val = pick_operand(uop_i.rs1_idx, rf_rs1_data_i, fwd_exe_i, fwd_wb_i);
    assign rs2_val = pick_operand(uop_i.rs2_idx, rf_rs2_data_i, fwd_exe_i, fwd_wb_i);

    // ==============================
    // build the execute op
    // ==============================
    always_comb begin
        op_d            = '0;
        op_d.valid      = uop_i.valid;
        op_d.alu_op     = uop_i.alu_op;
        op_d.opa        = rs1_val;
        // branches compare rs1/rs2 no matter what use_imm says
        op_d.opb        = (uop_i.use_imm && !uop_i.is_branch) ? uop_i.imm : rs2_val;
        op_d.imm        = uop_i.imm;
        op_d.pc         = uop_i.pc;
        op_d.pc_plus4   = uop_i.pc + XLEN'(4);
        op_d.rd_idx     = uop_i.rd_idx;
        op_d.reg_write  = uop_i.reg_write;
        op_d.res_src    = uop_i.res_src;
        op_d.is_branch  = uop_i.is_branch;
        op_d.is_jalr    = uop_i.is_jalr;
        op_d.pred_taken = uop_i.pred_taken;
    end

    // valid bit, flush beats stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            valid_q <= 1'b0;
        else if (flush_i)
            valid_q <= 1'b0;
        else if (!stall_i)
            valid_q <= uop_i.valid;
    end

    always_ff @(posedge clk) begin
        if (!stall_i)
            op_q <= op_d;    // hold during stall
    end

    always_comb begin
        exe_uop_o       = op_q;
        exe_uop_o.valid = valid_q;
    end

endmodule

/* src/exe_alu.sv */
`timescale 1ns/10ps

module exe_alu
    import exe_pkg::*;
(
    input  alu_op_e          alu_op_i,
    input  logic [XLEN-1:0]  opa_i,
    input  logic [XLEN-1:0]  opb_i,
    output logic [XLEN-1:0]  result_o,
    output logic             taken_o
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = opb_i[4:0];                      // only low 5 bits count
    assign eq    = (opa_i == opb_i);
    assign lt_s  = ($signed(opa_i) < $signed(opb_i));
    assign lt_u  = (opa_i < opb_i);

    // ==============================
    // datapath and compare
    // ==============================
    always_comb begin
        result_o = '0;
        taken_o  = 1'b0;
        unique case (alu_op_i)
            // arithmetic / logic
            ALU_ADD:  result_o = opa_i + opb_i;
            ALU_SUB:  result_o = opa_i - opb_i;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;

            // shifts
            ALU_SLL:  result_o = opa_i << shamt;
            ALU_SRL:  result_o = opa_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(opa_i) >>> shamt);

            // set less than
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};

            // branch compares, result stays zero
            ALU_BEQ:  taken_o = eq;
            ALU_BNE:  taken_o = !eq;
            ALU_BLT:  taken_o = lt_s;
            ALU_BGE:  taken_o = !lt_s;
            ALU_BLTU: taken_o = lt_u;
            ALU_BGEU: taken_o = !lt_u;
        endcase
    end

endmodule

/* src/exe_pkg.sv */
package exe_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int XLEN  = 32;   // data path
    localparam int NREG  = 32;   // architectural registers
    localparam int REG_W = 5;    // register index

    // ==============================
    // encodings
    // ==============================
    // alu ops, branch compares share the same field
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
        ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,   // alu result
        RES_IMM = 2'd1,   // lui style
        RES_PC4 = 2'd2    // link value for jal/jalr
    } res_src_e;

    // ==============================
    // stage payloads
    // ==============================
    // decoded op as it arrives from decode
    typedef struct packed {
        logic              valid;
        alu_op_e           alu_op;
        logic [REG_W-1:0]  rs1_idx;
        logic [REG_W-1:0]  rs2_idx;
        logic              use_imm;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic [REG_W-1:0]  rd_idx;
        logic              reg_write;
        res_src_e          res_src;
        logic              is_branch;
        logic              is_jalr;
        logic              pred_taken;   // static predictor decision
        logic [XLEN-1:0]   pred_pc;      // where fetch went
    } uop_t;

    // op sitting in the dispatch->execute register, operands resolved
    typedef struct packed {
        logic              valid;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   opa;
        logic [XLEN-1:0]   opb;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_plus4;
        logic [REG_W-1:0]  rd_idx;
        logic              reg_write;
        res_src_e          res_src;
        logic              is_branch;
        logic              is_jalr;
        logic              pred_taken;
    } exe_uop_t;

    // op sitting in the execute->writeback register
    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd_idx;
        logic              reg_write;
        res_src_e          res_src;
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc_plus4;
    } wb_uop_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd_idx;
        logic [XLEN-1:0]   data;
    } wb_port_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
    } redir_t;

endpackage

/* src/exe_stage.sv */
`timescale 1ns/10ps

module exe_stage
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  exe_uop_t  exe_uop_i,
    output redir_t    redir_o,
    output wb_port_t  fwd_exe_o,
    output wb_uop_t   wb_uop_o
);

    logic [XLEN-1:0] alu_res;
    logic            alu_taken;
    logic [XLEN-1:0] br_target;     // pc + imm
    logic [XLEN-1:0] exe_data;
    logic            writes_rd;
    wb_uop_t         wb_d;
    wb_uop_t         wb_q;          // payload only
    logic            valid_q;

    exe_alu u_alu (
        .alu_op_i (exe_uop_i.alu_op),
        .opa_i    (exe_uop_i.opa),
        .opb_i    (exe_uop_i.opb),
        .result_o (alu_res),
        .taken_o  (alu_taken)
    );

    assign br_target = exe_uop_i.pc + exe_uop_i.imm;

    // ==============================
    // redirect
    // ==============================
    always_comb begin
        redir_o = '0;
        if (exe_uop_i.valid) begin
            if (exe_uop_i.is_branch) begin
                if (alu_taken && !exe_uop_i.pred_taken) begin
                    redir_o.valid = 1'b1;              // missed a taken branch
                    redir_o.pc    = br_target;
                end else if (!alu_taken && exe_uop_i.pred_taken) begin
                    redir_o.valid = 1'b1;              // fall through after all
                    redir_o.pc    = exe_uop_i.pc_plus4;
                end
            end else if (exe_uop_i.is_jalr && !exe_uop_i.pred_taken) begin
                // rs1 + imm from the alu (add), bit 0 dropped
                redir_o.valid = 1'b1;
                redir_o.pc    = {alu_res[XLEN-1:1], 1'b0};
            end
        end
    end

    // ==============================
    // forward value and wb register
    // ==============================
    // branches never write, x0 writes are dropped here
    assign writes_rd = exe_uop_i.reg_write && !exe_uop_i.is_branch
                       && (exe_uop_i.rd_idx != '0);

    always_comb begin
        unique case (exe_uop_i.res_src)
            RES_IMM: exe_data = exe_uop_i.imm;
            RES_PC4: exe_data = exe_uop_i.pc_plus4;
            default: exe_data = alu_res;
        endcase
    end

    always_comb begin
        fwd_exe_o.valid  = exe_uop_i.valid && writes_rd;
        fwd_exe_o.rd_idx = exe_uop_i.rd_idx;
        fwd_exe_o.data   = exe_data;
    end

    always_comb begin
        wb_d.valid     = exe_uop_i.valid;
        wb_d.rd_idx    = exe_uop_i.rd_idx;
        wb_d.reg_write = writes_rd;
        wb_d.res_src   = exe_uop_i.res_src;
        wb_d.alu_res   = alu_res;
        wb_d.imm       = exe_uop_i.imm;
        wb_d.pc_plus4  = exe_uop_i.pc_plus4;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            valid_q <= 1'b0;
        else if (!stall_i)
            valid_q <= exe_uop_i.valid;
    end

    always_ff @(posedge clk) begin
        if (!stall_i)
            wb_q <= wb_d;
    end

    always_comb begin
        wb_uop_o       = wb_q;
        wb_uop_o.valid = valid_q;
    end

endmodule

/* src/exe_top.sv */
`timescale 1ns/10ps

module exe_top
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  uop_t      uop_i,
    output redir_t    redir_o,
    output wb_port_t  wb_o
);

    // ==============================
    // stage links
    // ==============================
    exe_uop_t         exe_uop;
    wb_uop_t          wb_uop;
    wb_port_t         fwd_exe;      // bypass from execute
    logic [REG_W-1:0] rf_rs1_idx;
    logic [REG_W-1:0] rf_rs2_idx;
    logic [XLEN-1:0]  rf_rs1_data;
    logic [XLEN-1:0]  rf_rs2_data;

    dispatch_stage u_dispatch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .uop_i         (uop_i),
        .rf_rs1_idx_o  (rf_rs1_idx),
        .rf_rs2_idx_o  (rf_rs2_idx),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .fwd_exe_i     (fwd_exe),
        .fwd_wb_i      (wb_o),         // writeback port doubles as bypass
        .exe_uop_o     (exe_uop)
    );

    exe_stage u_exe (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stall_i   (stall_i),
        .exe_uop_i (exe_uop),
        .redir_o   (redir_o),
        .fwd_exe_o (fwd_exe),
        .wb_uop_o  (wb_uop)
    );

    wb_regfile u_wb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .wb_uop_i   (wb_uop),
        .wb_o       (wb_o),
        .rs1_idx_i  (rf_rs1_idx),
        .rs2_idx_i  (rf_rs2_idx),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

endmodule

/* src/wb_regfile.sv */
`timescale 1ns/10ps

module wb_regfile
    import exe_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  wb_uop_t           wb_uop_i,
    output wb_port_t          wb_o,
    input  logic [REG_W-1:0]  rs1_idx_i,
    input  logic [REG_W-1:0]  rs2_idx_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o
);

    logic [XLEN-1:0] regs [NREG];
    logic [XLEN-1:0] wb_data;

    // ==============================
    // writeback select
    // ==============================
    always_comb begin
        unique case (wb_uop_i.res_src)
            RES_IMM: wb_data = wb_uop_i.imm;        // lui
            RES_PC4: wb_data = wb_uop_i.pc_plus4;   // link
            default: wb_data = wb_uop_i.alu_res;
        endcase
    end

    always_comb begin
        wb_o.valid  = wb_uop_i.valid && wb_uop_i.reg_write;
        wb_o.rd_idx = wb_uop_i.rd_idx;
        wb_o.data   = wb_data;
    end

    // ==============================
    // register file
    // ==============================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;
        end else if (wb_o.valid && !stall_i && (wb_o.rd_idx != '0)) begin
            regs[wb_o.rd_idx] <= wb_o.data;
        end
    end

    // async reads, x0 never written so it stays zero
    assign rs1_data_o = regs[rs1_idx_i];
    assign rs2_data_o = regs[rs2_idx_i];

endmodule

/* verif/exe_checker.sv */
`timescale 1ns/10ps

module exe_checker
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  redir_t    redir_i,
    input  wb_port_t  wb_i
);

    int fail_cnt = 0;    // summed into the closing line by exe_tb

    // x0 is never a writeback target
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_i.valid |-> (wb_i.rd_idx != '0))
        else begin
            $error("writeback valid with rd 0");
            fail_cnt++;
        end

    // flushed op is gone from execute one edge later
    flush_kills_redir: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !redir_i.valid)
        else begin
            $error("redirect valid in the cycle after a flush");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> (!redir_i.valid && !wb_i.valid))
        else begin
            $error("valid raised during reset");
            fail_cnt++;
        end

    stall_holds_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable(wb_i))
        else begin
            $error("writeback port changed under stall");
            fail_cnt++;
        end

endmodule

/* verif/exe_monitor.sv */
`timescale 1ns/10ps

module exe_monitor
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  uop_t      uop_i,
    input  redir_t    redir_i,
    input  wb_port_t  wb_i,
    output int        err_cnt_o,
    output int        chk_cnt_o
);

    logic [XLEN-1:0] rf_m [NREG];   // architectural register file
    exe_uop_t        ex_m;          // op in execute
    logic            ex_wr;         // ex_m will write rd
    wb_port_t        wb_m;          // op in writeback
    int              err_cnt = 0;
    int              chk_cnt = 0;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;

    // ==============================
    // reference ALU
    // ==============================
    function automatic logic [XLEN:0] ref_alu(input alu_op_e op,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ext;
        logic [XLEN-1:0]   sa;
        logic [XLEN-1:0]   sb;
        ext = {{XLEN{a[XLEN-1]}}, a};      // sign extended for sra
        sa  = a ^ 32'h8000_0000;           // biased, so unsigned compare orders signed
        sb  = b ^ 32'h8000_0000;
        case (op)   // msb is taken, rest is result
            ALU_ADD:  return {1'b0, a + b};
            ALU_SUB:  return {1'b0, a - b};
            ALU_AND:  return {1'b0, a & b};
            ALU_OR:   return {1'b0, a | b};
            ALU_XOR:  return {1'b0, a ^ b};
            ALU_SLL:  return {1'b0, a << b[4:0]};
            ALU_SRL:  return {1'b0, a >> b[4:0]};
            ALU_SRA:  return {1'b0, XLEN'(ext >> b[4:0])};
            ALU_SLT:  return {1'b0, XLEN'(sa < sb)};
            ALU_SLTU: return {1'b0, XLEN'(a < b)};
            ALU_BEQ:  return {a == b, XLEN'(0)};
            ALU_BNE:  return {a != b, XLEN'(0)};
            ALU_BLT:  return {sa < sb, XLEN'(0)};
            ALU_BGE:  return {sa >= sb, XLEN'(0)};
            ALU_BLTU: return {a < b, XLEN'(0)};
            default:  return {a >= b, XLEN'(0)};   // bgeu
        endcase
    endfunction

    function automatic logic [XLEN-1:0] ex_result();
        logic [XLEN:0] r;
        r = ref_alu(ex_m.alu_op, ex_m.opa, ex_m.opb);
        case (ex_m.res_src)
            RES_IMM: return ex_m.imm;
            RES_PC4: return ex_m.pc + 32'd4;
            default: return r[XLEN-1:0];
        endcase
    endfunction

    // newest producer first
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (ex_m.valid && ex_wr && (ex_m.rd_idx == idx))
            return ex_result();
        if (wb_m.valid && (wb_m.rd_idx == idx))
            return wb_m.data;
        return rf_m[idx];
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] exp_v,
                                 input logic [XLEN-1:0] act_v);
        chk_cnt++;
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h",
                     $time, name, exp_v, act_v);
        end
    endtask

    // ==============================
    // compare, then step to next edge
    // ==============================
    always @(negedge clk) begin : model
        logic          exp_rv;
        logic [XLEN-1:0] exp_pc;
        logic [XLEN:0]   r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        if (!arst_n_i) begin
            for (int i = 0; i < NREG; i++)
                rf_m[i] = '0;
            ex_m  = '0;
            ex_wr = 1'b0;
            wb_m  = '0;
        end else begin
            exp_rv = 1'b0;
            exp_pc = '0;
            r      = ref_alu(ex_m.alu_op, ex_m.opa, ex_m.opb);
            if (ex_m.valid && ex_m.is_branch) begin
                if (r[XLEN] && !ex_m.pred_taken) begin
                    exp_rv = 1'b1;                      // missed taken
                    exp_pc = ex_m.pc + ex_m.imm;
                end else if (!r[XLEN] && ex_m.pred_taken) begin
                    exp_rv = 1'b1;
                    exp_pc = ex_m.pc + 32'd4;
                end
            end else if (ex_m.valid && ex_m.is_jalr && !ex_m.pred_taken) begin
                exp_rv = 1'b1;
                exp_pc = (ex_m.opa + ex_m.imm) & ~32'h1;
            end
            compare_value("redir_o.valid", XLEN'(exp_rv), XLEN'(redir_i.valid));
            if (exp_rv)
                compare_value("redir_o.pc", exp_pc, redir_i.pc);
            compare_value("wb_o.valid", XLEN'(wb_m.valid), XLEN'(wb_i.valid));
            if (wb_m.valid) begin
                compare_value("wb_o.rd_idx", XLEN'(wb_m.rd_idx), XLEN'(wb_i.rd_idx));
                compare_value("wb_o.data", wb_m.data, wb_i.data);
            end

            // operands seen by dispatch at the coming edge
            a = read_reg(uop_i.rs1_idx);
            b = (uop_i.use_imm && !uop_i.is_branch) ? uop_i.imm : read_reg(uop_i.rs2_idx);
            if (!stall_i) begin
                if (wb_m.valid)
                    rf_m[wb_m.rd_idx] = wb_m.data;
                wb_m.valid  = ex_m.valid && ex_wr;
                wb_m.rd_idx = ex_m.rd_idx;
                wb_m.data   = ex_result();
                ex_m.valid      = uop_i.valid;
                ex_m.alu_op     = uop_i.alu_op;
                ex_m.opa        = a;
                ex_m.opb        = b;
                ex_m.imm        = uop_i.imm;
                ex_m.pc         = uop_i.pc;
                ex_m.rd_idx     = uop_i.rd_idx;
                ex_m.res_src    = uop_i.res_src;
                ex_m.is_branch  = uop_i.is_branch;
                ex_m.is_jalr    = uop_i.is_jalr;
                ex_m.pred_taken = uop_i.pred_taken;
                ex_wr = uop_i.reg_write && !uop_i.is_branch && (uop_i.rd_idx != '0);
            end
            if (flush_i)
                ex_m.valid = 1'b0;     // kills the op held in execute
        end
    end

endmodule

/* verif/exe_tb.sv */
`timescale 1ns/10ps

module exe_tb
    import exe_pkg::*;
();

    localparam int N_CYCLES = 2000;
    localparam int DRAIN    = 10;
    localparam int MARGIN   = 200;     // reset plus slack, in cycles
    localparam int CLK_NS   = 10;

    logic     clk;
    logic     arst_n;
    logic     stall;
    logic     flush;
    uop_t     uop;
    redir_t   redir;
    wb_port_t wb;
    int       err_cnt;
    int       chk_cnt;
    logic [15:0] lfsr_q;

    tb_clk_gen u_clk (.clk_o(clk), .arst_n_o(arst_n));

    exe_top uut (
        .clk      (clk),
        .arst_n_i (arst_n),
        .stall_i  (stall),
        .flush_i  (flush),
        .uop_i    (uop),
        .redir_o  (redir),
        .wb_o     (wb)
    );

    exe_monitor u_mon (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .stall_i   (stall),
        .flush_i   (flush),
        .uop_i     (uop),
        .redir_i   (redir),
        .wb_i      (wb),
        .err_cnt_o (err_cnt),
        .chk_cnt_o (chk_cnt)
    );

    bind exe_top exe_checker u_chk (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .redir_i  (redir_o),
        .wb_i     (wb_o)
    );

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);    // one step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // ==============================
    // random op, registers x0..x7
    // ==============================
    task automatic build_op(output uop_t u);
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  op_sel;
        logic [1:0]  br_bits;
        u = '0;
        take_bits(4, r);
        kind = r[3:0];
        take_bits(3, r);
        u.rs1_idx = REG_W'(r);
        take_bits(3, r);
        u.rs2_idx = REG_W'(r);
        take_bits(3, r);
        u.rd_idx = REG_W'(r);
        take_bits(32, r);
        u.imm = r;
        take_bits(30, r);
        u.pc = {r[29:0], 2'b00};
        take_bits(5, r);
        op_sel = r[4:0];                           // picks the alu or branch op
        take_bits(1, r);
        u.pred_taken = r[0];
        take_bits(2, r);
        br_bits = r[1:0];                          // branch write and imm flags
        u.valid      = 1'b1;
        u.reg_write  = 1'b1;
        u.res_src    = RES_ALU;
        u.use_imm    = (kind >= 4'd6);
        u.alu_op     = alu_op_e'(4'(op_sel % 10));
        if (kind == 4'd10)
            u.res_src = RES_IMM;                   // lui style
        else if (kind == 4'd11)
            u.res_src = RES_PC4;                   // link without redirect
        else if (kind >= 4'd12 && kind <= 4'd14) begin
            u.is_branch = 1'b1;
            u.alu_op    = alu_op_e'(4'(10 + op_sel % 6));
            u.reg_write = br_bits[0];              // must be ignored
            u.use_imm   = br_bits[1];
        end else if (kind == 4'd15) begin
            u.is_jalr = 1'b1;
            u.alu_op  = ALU_ADD;
            u.use_imm = 1'b1;
            u.res_src = RES_PC4;
        end
        u.pred_pc = u.pred_taken ? (u.pc + u.imm) : (u.pc + 32'd4);
    endtask

    initial begin
        uop_t        nxt;
        logic [31:0] r;
        logic        stall_c;
        logic        flush_c;
        int          err_total;
        lfsr_q = 16'd40830;
        stall  = 1'b0;
        flush  = 1'b0;
        uop    = '0;
        @(posedge arst_n);
        for (int c = 0; c < N_CYCLES; c++) begin
            @(posedge clk);
            take_bits(3, r);
            stall_c = (r[2:0] == 3'd0);            // about 1 in 8
            take_bits(4, r);
            flush_c = (r[3:0] == 4'd0);            // about 1 in 16
            build_op(nxt);
            if (stall_c)
                nxt.valid = 1'b0;                  // nothing offered while frozen
            stall <= stall_c;
            flush <= flush_c;
            uop   <= nxt;
        end
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        uop   <= '0;
        repeat (DRAIN) @(posedge clk);
        err_total = err_cnt + uut.u_chk.fail_cnt;
        $display("checks %0d, compare errors %0d, assertion errors %0d",
                 chk_cnt, err_cnt, uut.u_chk.fail_cnt);
        if (err_total == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #((N_CYCLES + DRAIN + MARGIN) * CLK_NS);
        $display("timeout: stimulus did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_NS = 5;    // 10 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    // held over two rising edges, released between edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #2 arst_n_o = 1'b1;
    end

endmodule
